/* fxp_pkg.sv */
package fxp_pkg;

    // Signed fixed-point format shared by both operand vectors and the result matrix.
    //
    // Operands of a and b are two's complement words.
    // The low FRAC_W bits are fraction and the rest are integer part.
    // With 8 bit cells and 4 fraction bits this is Q4.4.
    // The range is -8.0 to +7.9375 in steps of 1/16.
    //
    // A product of two Q4.4 values is Q8.8 at full precision.
    // The shift right by FRAC_W brings it back to 4 fraction bits.
    // Only the low RES_CELL_W bits are kept, so large products wrap.
    // Neither rounding nor saturation is applied to the result.

    // operand cell of vector a
    localparam int unsigned A_CELL_W = 8;

    // operand cell of vector b
    localparam int unsigned B_CELL_W = 8;

    // one cell of the result matrix, after shift and truncation
    localparam int unsigned RES_CELL_W = 8;

    // fraction bits of a and b
    // the result cell carries the same number of fraction bits
    localparam int unsigned FRAC_W = 4;

    // full signed product, wide enough that the multiply itself never overflows
    localparam int unsigned PROD_W = A_CELL_W + B_CELL_W;

    // Worked examples in this format:
    //   0x10 * 0x10 = 1.0 * 1.0     -> 0x0100 >>> 4 = 0x0010 -> 0x10
    //   0xF0 * 0x10 = -1.0 * 1.0    -> 0xFF00 >>> 4 = 0xFFF0 -> 0xF0
    //   0x80 * 0x80 = -8.0 * -8.0   -> 0x4000 >>> 4 = 0x0400 -> 0x00 (wraps)
    //   0x7F * 0x7F = 7.94 * 7.94   -> 0x3F01 >>> 4 = 0x03F0 -> 0xF0 (wraps)
    //
    // The arithmetic shift keeps the sign of the product.
    // Negative results are rounded towards minus infinity by the shift.
    // That matches the behaviour of the existing reference block.

endpackage

/* op_geom_pkg.sv */
package op_geom_pkg;

    // Shape of the outer product and the way it is cut into tiles.
    // Row i of the result comes from element i of a.
    // Column j of the result comes from element j of b.

    localparam int unsigned A_LEN = 5;    // elements in a, rows of the result
    localparam int unsigned B_LEN = 5;    // elements in b, columns of the result

    // one tile is TILE_V rows by TILE_H columns, computed in one clock
    localparam int unsigned TILE_V = 1;
    localparam int unsigned TILE_H = 2;

    // tile counts round up, so the last tile may hang over the vector end
    localparam int unsigned N_TILES_V = (A_LEN + TILE_V - 1) / TILE_V;
    localparam int unsigned N_TILES_H = (B_LEN + TILE_H - 1) / TILE_H;

    // clocks spent in run for one full product
    localparam int unsigned N_TILES = N_TILES_V * N_TILES_H;

    // tile counters count 0 .. N_TILES_x - 1
    // a single tile in one direction still gets a one bit counter
    localparam int unsigned ROW_CNT_W = (N_TILES_V > 1) ? $clog2(N_TILES_V) : 1;
    localparam int unsigned COL_CNT_W = (N_TILES_H > 1) ? $clog2(N_TILES_H) : 1;

    // With 5 by 5 and 1 by 2 tiles:
    //   5 row tiles, 3 column tiles, 15 tiles in all
    //   column tile 2 covers columns 4 and 5, and column 5 does not exist
    //   row counter is 3 bits, column counter is 2 bits
    //
    // Tiles are walked row by row.
    // The column counter is the inner one and the row counter the outer one.

endpackage

/* tile_sequencer.sv */
`timescale 1ns/1ps

module tile_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    output logic [op_geom_pkg::ROW_CNT_W-1:0] tile_row,
    output logic [op_geom_pkg::COL_CNT_W-1:0] tile_col,
    output logic                              tile_we,
    output logic                              busy,
    output logic                              valid
);

    import op_geom_pkg::*;

    // Two-state control: idle when running is low, run when it is high.
    // A start seen while idle is accepted and the tiles are walked one per clock.
    // The column counter is the inner loop and the row counter the outer loop.

    logic running;      // run state
    logic done;         // last tile written on the previous edge
    logic accept;       // start taken while idle
    logic last_col;
    logic last_row;

    assign accept   = start && !running;
    assign last_col = (tile_col == COL_CNT_W'(N_TILES_H - 1));
    assign last_row = (tile_row == ROW_CNT_W'(N_TILES_V - 1));

    // one tile written on every clock spent in run
    assign tile_we = running;
    assign busy    = running;

    // state and tile counters
    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            tile_row <= '0;
            tile_col <= '0;
        end else if (accept) begin
            running  <= 1'b1;
            tile_row <= '0;
            tile_col <= '0;
        end else if (running) begin
            if (last_col) begin
                tile_col <= '0;
                if (last_row) begin
                    // final tile goes out on this edge
                    running  <= 1'b0;
                    tile_row <= '0;
                end else begin
                    tile_row <= tile_row + 1'b1;
                end
            end else begin
                tile_col <= tile_col + 1'b1;
            end
        end
    end

    // Completion status.
    // done marks the edge that wrote the last tile,
    // valid follows one edge later and holds until the next accepted start
    always_ff @(posedge clk) begin
        if (rst) begin
            done  <= 1'b0;
            valid <= 1'b0;
        end else if (accept) begin
            done  <= 1'b0;
            valid <= 1'b0;              // new run, old matrix is stale
        end else begin
            done <= running && last_row && last_col;
            if (done) begin
                valid <= 1'b1;
            end
        end
    end

endmodule

/* tile_multiplier.sv */
`timescale 1ns/1ps

module tile_multiplier (
    input  logic [op_geom_pkg::TILE_V*fxp_pkg::A_CELL_W-1:0]                     tile_a,
    input  logic [op_geom_pkg::TILE_H*fxp_pkg::B_CELL_W-1:0]                     tile_b,
    output logic [op_geom_pkg::TILE_V*op_geom_pkg::TILE_H*fxp_pkg::RES_CELL_W-1:0] tile_prod
);

    import fxp_pkg::*;
    import op_geom_pkg::*;

    // Every a cell of the tile times every b cell of the tile.
    // Purely combinational; the product for row r, column c
    // lands at cell index r * TILE_H + c of tile_prod.

    for (genvar r = 0; r < TILE_V; r++) begin : g_row
        for (genvar c = 0; c < TILE_H; c++) begin : g_col
            logic signed [A_CELL_W-1:0] a_cell;
            logic signed [B_CELL_W-1:0] b_cell;
            logic signed [PROD_W-1:0]   prod_full;   // Q8.8 for Q4.4 operands
            logic signed [PROD_W-1:0]   prod_shift;  // back to FRAC_W fraction bits

            assign a_cell = tile_a[r*A_CELL_W +: A_CELL_W];
            assign b_cell = tile_b[c*B_CELL_W +: B_CELL_W];

            // both operands are sign extended to PROD_W by the signed context
            assign prod_full = a_cell * b_cell;

            // arithmetic shift keeps the sign
            assign prod_shift = prod_full >>> FRAC_W;

            // low bits only, large products wrap
            assign tile_prod[(r*TILE_H + c)*RES_CELL_W +: RES_CELL_W] =
                prod_shift[RES_CELL_W-1:0];
        end
    end

endmodule

/* result_store.sv */
`timescale 1ns/1ps

module result_store (
    input  logic                                                  clk,
    input  logic                                                  tile_we,
    input  logic [op_geom_pkg::ROW_CNT_W-1:0]                     tile_row,
    input  logic [op_geom_pkg::COL_CNT_W-1:0]                     tile_col,
    input  logic [op_geom_pkg::TILE_V*op_geom_pkg::TILE_H*fxp_pkg::RES_CELL_W-1:0] tile_prod,
    output logic [op_geom_pkg::A_LEN*op_geom_pkg::B_LEN*fxp_pkg::RES_CELL_W-1:0]   result
);

    import fxp_pkg::*;
    import op_geom_pkg::*;

    // Holds the full A_LEN by B_LEN result matrix.
    // Contents are only meaningful once a run has completed.

    logic [RES_CELL_W-1:0] cells [A_LEN][B_LEN];

    int unsigned row_base;    // first matrix row covered by the current tile
    int unsigned col_base;    // first matrix column covered by the current tile

    always_comb begin
        row_base = int'(tile_row) * TILE_V;
        col_base = int'(tile_col) * TILE_H;
    end

    // tile write
    // cells of an overhanging tile that fall past the vector end are dropped,
    // with 5 columns and 2 wide tiles that is column 5 of the last column tile
    always_ff @(posedge clk) begin
        if (tile_we) begin
            for (int r = 0; r < TILE_V; r++) begin
                for (int c = 0; c < TILE_H; c++) begin
                    if ((row_base + r < A_LEN) && (col_base + c < B_LEN)) begin
                        cells[row_base + r][col_base + c] <=
                            tile_prod[(r*TILE_H + c)*RES_CELL_W +: RES_CELL_W];
                    end
                end
            end
        end
    end

    // flat output, row i column j at cell index i * B_LEN + j
    for (genvar i = 0; i < A_LEN; i++) begin : g_out_row
        for (genvar j = 0; j < B_LEN; j++) begin : g_out_col
            assign result[(i*B_LEN + j)*RES_CELL_W +: RES_CELL_W] = cells[i][j];
        end
    end

endmodule

/* tensor_product.sv */
`timescale 1ns/1ps

module tensor_product (
    input  logic                                                                  clk,
    input  logic                                                                  rst,
    input  logic                                                                  start,
    input  logic [op_geom_pkg::A_LEN*fxp_pkg::A_CELL_W-1:0]                       a,
    input  logic [op_geom_pkg::B_LEN*fxp_pkg::B_CELL_W-1:0]                       b,
    output logic [op_geom_pkg::A_LEN*op_geom_pkg::B_LEN*fxp_pkg::RES_CELL_W-1:0] result,
    output logic                                                                  valid
);

    import fxp_pkg::*;
    import op_geom_pkg::*;

    // Outer product of a and b.
    // Operands are captured on the accepting edge, then the sequencer walks
    // the result one tile per clock through the multiplier into the store.

    logic [A_LEN*A_CELL_W-1:0] a_q;      // captured operands
    logic [B_LEN*B_CELL_W-1:0] b_q;

    // operands padded out to whole tiles, padding reads as zero
    logic [N_TILES_V*TILE_V*A_CELL_W-1:0] a_pad;
    logic [N_TILES_H*TILE_H*B_CELL_W-1:0] b_pad;

    logic [ROW_CNT_W-1:0] tile_row;
    logic [COL_CNT_W-1:0] tile_col;
    logic                 tile_we;
    logic                 busy;
    logic                 accept;

    logic [TILE_V*A_CELL_W-1:0]            tile_a;
    logic [TILE_H*B_CELL_W-1:0]            tile_b;
    logic [TILE_V*TILE_H*RES_CELL_W-1:0]   tile_prod;

    // same accept rule as inside the sequencer
    assign accept = start && !busy;

    // inputs may change freely once the run has started
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= a;
            b_q <= b;
        end
    end

    always_comb begin
        a_pad                      = '0;
        a_pad[A_LEN*A_CELL_W-1:0]  = a_q;
        b_pad                      = '0;
        b_pad[B_LEN*B_CELL_W-1:0]  = b_q;   // last column tile sees zero past B_LEN
    end

    assign tile_a = a_pad[tile_row*TILE_V*A_CELL_W +: TILE_V*A_CELL_W];
    assign tile_b = b_pad[tile_col*TILE_H*B_CELL_W +: TILE_H*B_CELL_W];

    tile_sequencer u_seq (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .tile_row (tile_row),
        .tile_col (tile_col),
        .tile_we  (tile_we),
        .busy     (busy),
        .valid    (valid)
    );

    tile_multiplier u_mul (
        .tile_a    (tile_a),
        .tile_b    (tile_b),
        .tile_prod (tile_prod)
    );

    result_store u_store (
        .clk       (clk),
        .tile_we   (tile_we),
        .tile_row  (tile_row),
        .tile_col  (tile_col),
        .tile_prod (tile_prod),
        .result    (result)
    );

endmodule

/* tensor_product_props.sv */
`timescale 1ns/1ps

module tensor_product_props (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic tile_we,
    input logic valid
);

    import op_geom_pkg::*;

    int unsigned fail_count = 0;    // failed assertions so far

    logic accept;

    assign accept = start && !busy;

    // control outputs come out of reset low
    property p_reset_clear;
        @(posedge clk) rst |=> (!valid && !tile_we);
    endproperty

    // one run is N_TILES clocks of busy, a gap edge, then valid
    property p_run_length;
        @(posedge clk) disable iff (rst)
            accept |=> busy [*N_TILES] ##1 (!busy && !valid) ##1 valid;
    endproperty

    // one tile write per clock of the run and none after it
    property p_we_window;
        @(posedge clk) disable iff (rst)
            accept |=> tile_we [*N_TILES] ##1 !tile_we;
    endproperty

    // the only way valid drops is a newly accepted start
    property p_valid_hold;
        @(posedge clk) disable iff (rst) $fell(valid) |-> $past(accept);
    endproperty

    a_reset_clear: assert property (p_reset_clear) else begin
        $error("valid or tile_we high in the cycle after reset");
        fail_count++;
    end

    a_run_length: assert property (p_run_length) else begin
        $error("busy length or valid timing wrong after an accepted start");
        fail_count++;
    end

    a_we_window: assert property (p_we_window) else begin
        $error("tile_we not high for exactly the run after an accepted start");
        fail_count++;
    end

    a_valid_hold: assert property (p_valid_hold) else begin
        $error("valid fell without an accepted start");
        fail_count++;
    end

endmodule

bind tile_sequencer tensor_product_props u_props (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .busy    (busy),
    .tile_we (tile_we),
    .valid   (valid)
);

/* tb_tensor_product.sv */
`timescale 1ns/1ps

module tb_tensor_product;

    import fxp_pkg::*;
    import op_geom_pkg::*;

    localparam int unsigned A_W   = A_LEN * A_CELL_W;
    localparam int unsigned B_W   = B_LEN * B_CELL_W;
    localparam int unsigned RES_W = A_LEN * B_LEN * RES_CELL_W;

    // each operand run counts as one unit of the cycle budget
    localparam int unsigned N_RANDOM       = 20;
    localparam int unsigned N_RUNS         = 4 + N_RANDOM;
    localparam int unsigned TIMEOUT_CYCLES = N_RUNS * (N_TILES + 10) + 50;

    logic             clk;
    logic             rst;
    logic             start;
    logic [A_W-1:0]   a;
    logic [B_W-1:0]   b;
    logic [RES_W-1:0] result;
    logic             valid;

    int unsigned cycle_cnt = 0;
    int unsigned accept_cycle;          // cycle count just after the accepting edge
    int unsigned check_errors;
    int unsigned tests_passed;
    int unsigned tests_failed;
    int unsigned errs_at_test_start;

    tensor_product dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .a      (a),
        .b      (b),
        .result (result),
        .valid  (valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycle counter and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // testbench checks plus bound assertion failures
    function automatic int unsigned error_total();
        return check_errors + dut.u_seq.u_props.fail_count;
    endfunction

    // expected cell: signed product, arithmetic shift, low bits kept
    function automatic logic [RES_CELL_W-1:0] model_cell(input logic [A_CELL_W-1:0] av,
                                                         input logic [B_CELL_W-1:0] bv);
        int prod;
        prod = int'($signed(av)) * int'($signed(bv));
        prod = prod >>> FRAC_W;
        return prod[RES_CELL_W-1:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // start pulse with operands, returns just after the accepting edge
    task automatic launch(input logic [A_W-1:0] av, input logic [B_W-1:0] bv);
        a     = av;
        b     = bv;
        start = 1'b1;
        next_cycle();
        start        = 1'b0;
        accept_cycle = cycle_cnt;
        assert (valid === 1'b0) else begin
            $display("FAILED valid after start expected %h got %h", 1'b0, valid);
            check_errors++;
        end
    endtask

    task automatic wait_valid();
        int unsigned latency;
        while (valid !== 1'b1) begin
            next_cycle();
        end
        latency = cycle_cnt - accept_cycle;
        assert (latency == N_TILES + 1) else begin
            $display("FAILED valid latency expected %h got %h", N_TILES + 1, latency);
            check_errors++;
        end
    endtask

    task automatic check_result(input logic [A_W-1:0] av, input logic [B_W-1:0] bv);
        logic [RES_CELL_W-1:0] exp_cell;
        logic [RES_CELL_W-1:0] got_cell;
        for (int i = 0; i < A_LEN; i++) begin
            for (int j = 0; j < B_LEN; j++) begin
                exp_cell = model_cell(av[i*A_CELL_W +: A_CELL_W], bv[j*B_CELL_W +: B_CELL_W]);
                got_cell = result[(i*B_LEN + j)*RES_CELL_W +: RES_CELL_W];
                assert (got_cell === exp_cell) else begin
                    $display("FAILED result row %0d col %0d expected %h got %h",
                             i, j, exp_cell, got_cell);
                    check_errors++;
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        int unsigned errs;
        errs = error_total() - errs_at_test_start;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errs);
        end
        errs_at_test_start = error_total();
    endtask

    initial begin
        logic [A_W-1:0] av;
        logic [B_W-1:0] bv;
        int unsigned    gap;

        void'($urandom(45544));
        rst                = 1'b1;
        start              = 1'b0;
        a                  = '0;
        b                  = '0;
        check_errors       = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        errs_at_test_start = 0;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // nothing started after reset
        repeat (10) begin
            next_cycle();
            assert (valid === 1'b0) else begin
                $display("FAILED valid without start expected %h got %h", 1'b0, valid);
                check_errors++;
            end
        end
        end_test("reset");

        // a holds 1.0, -1.0, -8.0, 2.5, -1.5 and b holds 0.5, -8.0, -1.0, max, -3.75
        av = {8'hE8, 8'h28, 8'h80, 8'hF0, 8'h10};
        bv = {8'hC4, 8'h7F, 8'hF0, 8'h80, 8'h08};
        launch(av, bv);
        wait_valid();
        check_result(av, bv);
        repeat (3) next_cycle();
        assert (valid === 1'b1) else begin
            $display("FAILED valid hold expected %h got %h", 1'b1, valid);
            check_errors++;
        end
        check_result(av, bv);                   // matrix held while idle
        end_test("known vectors");

        // inputs move right after the accepting edge
        av = A_W'({$urandom(), $urandom()});
        bv = B_W'({$urandom(), $urandom()});
        launch(av, bv);
        a = ~av;
        b = B_W'({$urandom(), $urandom()});
        wait_valid();
        check_result(av, bv);
        next_cycle();                           // run-length property ends one edge after valid
        end_test("operand capture");

        // start pulses in the middle of a run
        av = A_W'({$urandom(), $urandom()});
        bv = B_W'({$urandom(), $urandom()});
        launch(av, bv);
        repeat (3) next_cycle();
        a     = A_W'({$urandom(), $urandom()});
        b     = B_W'({$urandom(), $urandom()});
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (4) next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        wait_valid();
        check_result(av, bv);
        next_cycle();
        end_test("ignored start");

        // back to back random runs
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = $urandom_range(5, 0);
            repeat (gap) next_cycle();
            av = A_W'({$urandom(), $urandom()});
            bv = B_W'({$urandom(), $urandom()});
            launch(av, bv);
            wait_valid();
            check_result(av, bv);
        end
        next_cycle();
        end_test("random runs");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_total() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
fxp_pkg.sv
op_geom_pkg.sv
tile_sequencer.sv
tile_multiplier.sv
result_store.sv
tensor_product.sv
tensor_product_props.sv
tb_tensor_product.sv
